// File: verilog.f
+incdir+.
uart_pkg.sv
bridge_pkg.sv
uart_byte_if.sv
uart_rx.sv
uart_tx.sv
gpio_bridge.sv
board_top.sv
uart_reply_checker.sv
board_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds board_top_tb with Verilator from the project root, runs it and checks the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module board_top_tb \
  -f verilog.f -o board_sim || { echo "build failed"; exit 1; }

out=$(./obj_dir/board_sim)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "No errors" && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}

// File: board_stimulus.txt
# columns: cmd data sw reply led stop, all hex; data none = single byte command
# reply noreply = no frame expected; stop bad = last byte goes out with a low stop bit
57 00   0 4b      00 ok
57 ff   0 4b      ff ok
57 a5   0 4b      a5 ok
52 none 3 03      a5 ok
52 none a 0a      a5 ok
52 none f 0f      a5 ok
52 none 0 00      a5 ok
00 none 0 3f      a5 ok
41 none 5 3f      a5 ok
ff none 0 3f      a5 ok
57 3c   0 noreply a5 bad
57 3c   0 4b      3c ok
52 none 5 05      3c ok
57 81   9 4b      81 ok
72 none 0 3f      81 ok

// File: board_top_tb.sv
// host model for board_top; board_stimulus.txt is read from the project root, one line per test
`default_nettype none

`include "soc_defines.svh"

module board_top_tb import bridge_pkg::*; ();

  localparam int N          = `SOC_CLKS_PER_BIT;
  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 8;
  localparam int DRIVE_DLY  = 2;
  localparam int SEED       = 32;

  localparam logic [63:0] TOK_COMMENT = "#";
  localparam logic [63:0] TOK_NONE    = "none";
  localparam logic [63:0] TOK_NOREPLY = "noreply";
  localparam logic [63:0] TOK_BAD     = "bad";

  logic clk;
  logic rst;
  logic uart_rx;
  sw_t  sw;
  logic uart_tx;
  led_t led;

  // expectations handed to the checker
  logic        arm;
  int          exp_test_id;
  int          exp_frames;
  logic        exp_has_reply;
  reply_code_t exp_reply;
  led_t        exp_led;
  int          checked;
  int          failed;

  // one entry per stimulus line
  logic [7:0] q_cmd[$];
  logic [7:0] q_data[$];
  logic [7:0] q_sw[$];
  logic [7:0] q_reply[$];
  logic [7:0] q_led[$];
  bit         q_has_data[$];
  bit         q_has_reply[$];
  bit         q_bad_stop[$];

  int cycles;
  int cycle_limit;
  int gap;
  int t;

  board_top dut0 (
    .clk       (clk),
    .i_rst     (rst),
    .i_uart_rx (uart_rx),
    .i_sw      (sw),
    .o_uart_tx (uart_tx),
    .o_led     (led)
  );

  uart_reply_checker u_checker (
    .clk         (clk),
    .i_rst       (rst),
    .i_uart_tx   (uart_tx),
    .i_led       (led),
    .i_arm       (arm),
    .i_test_id   (exp_test_id),
    .i_frames    (exp_frames),
    .i_has_reply (exp_has_reply),
    .i_exp_reply (exp_reply),
    .i_exp_led   (exp_led),
    .o_checked   (checked),
    .o_failed    (failed)
  );

  // ====================
  // clock and timeout
  // ====================

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      end_with_failure($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
    end
  end

  task automatic end_with_failure(input string reason);
    $display("%s", reason);
    $display("summary: %0d tests checked, %0d passed, %0d failed",
             checked, checked - failed, failed);
    $display("Errors found");
    $finish;
  endtask

  // ====================
  // stimulus file
  // ====================

  // converts a right-justified ascii hex token to a byte
  function automatic logic [7:0] hex_byte(input logic [63:0] tok);
    logic [7:0] val;
    logic [7:0] c;
    logic [7:0] d;
    int         i;
    val = '0;
    for (i = 7; i >= 0; i--) begin
      c = tok[i*8 +: 8];
      d = 8'h00;
      if (c >= 8'h30 && c <= 8'h39) begin
        d = c - 8'h30;
      end else if (c >= 8'h61 && c <= 8'h66) begin
        d = c - 8'h57;
      end else if (c >= 8'h41 && c <= 8'h46) begin
        d = c - 8'h37;
      end
      if (c != 8'h00) begin
        val = {val[3:0], d[3:0]};
      end
    end
    return val;
  endfunction

  task automatic load_stimulus();
    int              fd;
    int              n;
    logic [8*96-1:0] line;
    logic [63:0]     tk_cmd;
    logic [63:0]     tk_data;
    logic [63:0]     tk_sw;
    logic [63:0]     tk_reply;
    logic [63:0]     tk_led;
    logic [63:0]     tk_stop;
    fd = $fopen("board_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open board_stimulus.txt");
    end else begin
      while (!$feof(fd)) begin
        line    = '0;
        tk_cmd  = '0;
        n       = $fgets(line, fd);
        n       = $sscanf(line, "%s %s %s %s %s %s",
                          tk_cmd, tk_data, tk_sw, tk_reply, tk_led, tk_stop);
        // comment lines open with a lone hash
        if (n == 6 && tk_cmd != TOK_COMMENT) begin
          q_cmd.push_back(hex_byte(tk_cmd));
          q_has_data.push_back(tk_data != TOK_NONE);
          q_data.push_back(hex_byte(tk_data));
          q_sw.push_back(hex_byte(tk_sw));
          q_has_reply.push_back(tk_reply != TOK_NOREPLY);
          q_reply.push_back(hex_byte(tk_reply));
          q_led.push_back(hex_byte(tk_led));
          q_bad_stop.push_back(tk_stop == TOK_BAD);
        end
      end
      $fclose(fd);
    end
  endtask

  // ====================
  // serial host driver
  // ====================

  // start, eight data bits lsb first, stop; each bit N cycles, line back to idle after
  task automatic send_frame(input logic [7:0] data, input bit bad_stop);
    logic [9:0] frame;
    int         b;
    frame = {!bad_stop, data, 1'b0};
    for (b = 0; b < 10; b++) begin
      @(posedge clk);
      #DRIVE_DLY;
      uart_rx = frame[b];
      repeat (N - 1) @(posedge clk);
    end
    @(posedge clk);
    #DRIVE_DLY;
    uart_rx = 1'b1;
  endtask

  task automatic wait_checked(input int count);
    while (checked < count) begin
      @(posedge clk);
    end
  endtask

  task automatic run_test(input int idx);
    @(posedge clk);
    #DRIVE_DLY;
    // switches settle through the synchronizer long before the command ends
    sw            = sw_t'(q_sw[idx]);
    exp_test_id   = idx + 1;
    exp_frames    = q_has_data[idx] ? 2 : 1;
    exp_has_reply = q_has_reply[idx];
    exp_reply     = q_reply[idx];
    exp_led       = led_t'(q_led[idx]);
    arm           = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    arm = 1'b0;
    // a bad stop bit goes on the last byte of the line
    send_frame(q_cmd[idx], q_bad_stop[idx] && !q_has_data[idx]);
    if (q_has_data[idx]) begin
      send_frame(q_data[idx], q_bad_stop[idx]);
    end
    wait_checked(idx + 2);
  endtask

  // ====================
  // main sequence
  // ====================

  initial begin
    rst           = 1'b1;
    uart_rx       = 1'b1;
    sw            = '0;
    arm           = 1'b0;
    exp_test_id   = 0;
    exp_frames    = 1;
    exp_has_reply = 1'b0;
    exp_reply     = '0;
    exp_led       = '0;
    cycles        = 0;
    cycle_limit   = 0;
    void'($urandom(SEED));
    load_stimulus();
    if (q_cmd.size() == 0) begin
      end_with_failure("no test lines read from board_stimulus.txt");
    end else begin
      cycle_limit = q_cmd.size() * 30 * N + RST_CYCLES;
      repeat (RST_CYCLES) @(posedge clk);
      #DRIVE_DLY;
      rst = 1'b0;
      // reset state is test 0
      wait_checked(1);
      for (t = 0; t < q_cmd.size(); t++) begin
        run_test(t);
        // random idle gap on the line between commands
        gap = int'($urandom_range(0, 2 * N));
        repeat (gap) @(posedge clk);
      end
      $display("summary: %0d tests checked, %0d passed, %0d failed",
               checked, checked - failed, failed);
      if (failed == 0) begin
        $display("No errors");
      end else begin
        $display("Errors found");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: uart_reply_checker.sv
// decodes reply frames on o_uart_tx at mid-bit; expects the host to arm it before each command
`default_nettype none

`include "soc_defines.svh"

module uart_reply_checker import bridge_pkg::*; (
  input  logic        clk,
  input  logic        i_rst,
  input  logic        i_uart_tx,
  input  led_t        i_led,
  input  logic        i_arm,
  input  int          i_test_id,
  input  int          i_frames,
  input  logic        i_has_reply,
  input  reply_code_t i_exp_reply,
  input  led_t        i_exp_led,
  output int          o_checked,
  output int          o_failed
);

  localparam int N = `SOC_CLKS_PER_BIT;

  // mismatches seen in the test that is running
  int test_errs;

  // ====================
  // reporting
  // ====================

  task automatic report_mismatch(input string sig, input logic [7:0] got,
                                 input logic [7:0] exp);
    $display("[FAIL] time %0t: %s got 0x%02h expected 0x%02h", $time, sig, got, exp);
    test_errs++;
  endtask

  // one line per finished test, then bump the counters the testbench reads
  task automatic close_test(input int id);
    if (test_errs == 0) begin
      $display("test %0d: pass", id);
    end else begin
      $display("test %0d: fail with %0d problem(s)", id, test_errs);
      o_failed++;
    end
    o_checked++;
  endtask

  // ====================
  // frame decoder
  // ====================

  // all sampling on the falling edge, the line only moves on the rising edge
  task automatic catch_frame(input int window, output bit seen, output logic [7:0] data,
                             output bit stop_ok);
    int waited;
    int b;
    seen    = 1'b0;
    data    = '0;
    stop_ok = 1'b0;
    waited  = 0;
    // hunt for the start bit inside the window
    while (!seen && waited < window) begin
      @(negedge clk);
      waited++;
      if (!i_uart_tx) begin
        seen = 1'b1;
      end
    end
    if (seen) begin
      // first low sample is half a clock into the start bit, move to its middle
      repeat (N / 2 - 1) @(negedge clk);
      for (b = 0; b < 8; b++) begin
        repeat (N) @(negedge clk);
        data[b] = i_uart_tx;
      end
      repeat (N) @(negedge clk);
      stop_ok = i_uart_tx;
    end
  endtask

  // window covers the command frames plus two frame times for the reply
  task automatic check_command();
    int         window;
    bit         seen;
    bit         stop_ok;
    logic [7:0] got;
    test_errs = 0;
    window    = (i_frames + 2) * 10 * N;
    catch_frame(window, seen, got, stop_ok);
    if (i_has_reply) begin
      if (!seen) begin
        $display("test %0d: no reply frame within two frame times after the command",
                 i_test_id);
        test_errs++;
      end else begin
        if (got !== i_exp_reply) begin
          report_mismatch("o_uart_tx reply byte", got, i_exp_reply);
        end
        if (!stop_ok) begin
          $display("test %0d: reply frame ended with a low stop bit", i_test_id);
          test_errs++;
        end
      end
    end else if (seen) begin
      $display("test %0d: reply frame 0x%02h arrived where no reply was expected",
               i_test_id, got);
      test_errs++;
    end
    // leds have settled by the reply stop bit or the end of the window
    if (i_led !== i_exp_led) begin
      report_mismatch("o_led", i_led, i_exp_led);
    end
    close_test(i_test_id);
  endtask

  // ====================
  // main loop
  // ====================

  initial begin
    o_checked = 0;
    o_failed  = 0;
    // idle state right after reset, before the host sends anything
    @(negedge clk);
    while (i_rst) begin
      @(negedge clk);
    end
    test_errs = 0;
    if (i_uart_tx !== 1'b1) begin
      report_mismatch("o_uart_tx", {7'd0, i_uart_tx}, 8'h01);
    end
    if (i_led !== '0) begin
      report_mismatch("o_led", i_led, 8'h00);
    end
    close_test(0);
    forever begin
      @(negedge clk);
      if (i_arm) begin
        check_command();
      end
    end
  end

endmodule

`default_nettype wire

// File: board_top.sv
// board top with a serial command port; single clock domain, switches and rx treated as async
`default_nettype none

module board_top import bridge_pkg::*; (
  input  logic clk,
  input  logic i_rst,
  input  logic i_uart_rx,
  input  sw_t  i_sw,
  output logic o_uart_tx,
  output led_t o_led
);

  // ====================
  // byte link
  // ====================

  // shared between receiver, transmitter and bridge
  uart_byte_if link ();

  // ====================
  // serial port
  // ====================

  // host to board
  uart_rx u_rx (
    .clk    (clk),
    .i_rst  (i_rst),
    .i_rx   (i_uart_rx),
    .o_link (link.rx)
  );

  // board to host, replies only
  uart_tx u_tx (
    .clk    (clk),
    .i_rst  (i_rst),
    .i_link (link.tx),
    .o_tx   (o_uart_tx)
  );

  // ====================
  // command bridge
  // ====================

  // leds and switches sit behind the bridge
  gpio_bridge u_bridge (
    .clk     (clk),
    .i_rst   (i_rst),
    .io_link (link.bridge),
    .i_sw    (i_sw),
    .o_led   (o_led)
  );

endmodule

`default_nettype wire

// File: gpio_bridge.sv
// single-command bridge, no receive queue; host must wait for each reply before the next command
`default_nettype none

module gpio_bridge import bridge_pkg::*; (
  input  logic        clk,
  input  logic        i_rst,
  uart_byte_if.bridge io_link,
  input  sw_t         i_sw,
  output led_t        o_led
);

  bridge_state_t state;
  sw_t           sw_meta;
  sw_t           sw_sync;
  reply_code_t   reply_q;

  // ====================
  // switch synchronizer
  // ====================

  // dip switches are asynchronous, two flops before use
  // a read reply sees i_sw two cycles late
  always_ff @(posedge clk) begin
    sw_meta <= i_sw;
    sw_sync <= sw_meta;
  end

  // ====================
  // command fsm
  // ====================

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state <= BR_WAIT_CMD;
      o_led <= '0;
    end else begin
      case (state)
        BR_WAIT_CMD: begin
          // a frame error here is simply dropped
          if (io_link.rx_strobe) begin
            // read and unknown codes answer at once, only a write needs data
            if (io_link.rx_byte == CMD_WRITE_LED) begin
              state <= BR_WAIT_DATA;
            end else begin
              state <= BR_SEND_REPLY;
            end
          end
        end
        BR_WAIT_DATA: begin
          if (io_link.rx_frame_err) begin
            // a broken data byte abandons the write without a reply
            state <= BR_WAIT_CMD;
          end else if (io_link.rx_strobe) begin
            // leds follow one cycle after the data strobe
            o_led <= led_t'(io_link.rx_byte);
            state <= BR_SEND_REPLY;
          end
        end
        BR_SEND_REPLY: begin
          // wait here while the transmitter still sends the previous frame
          if (!io_link.tx_busy) begin
            state <= BR_WAIT_CMD;
          end
        end
        default: state <= BR_WAIT_CMD;
      endcase
    end
  end

  // reply byte is loaded when a command completes
  always_ff @(posedge clk) begin
    if (io_link.rx_strobe) begin
      if (state == BR_WAIT_CMD) begin
        case (io_link.rx_byte)
          // switches zero-extended to a full byte
          CMD_READ_SW: reply_q <= reply_code_t'(sw_sync);
          CMD_WRITE_LED: reply_q <= RPL_ACK;
          default: reply_q <= RPL_UNKNOWN;
        endcase
      end else if (state == BR_WAIT_DATA) begin
        reply_q <= RPL_ACK;
      end
    end
  end

  // start goes out the first cycle in send reply with the transmitter free
  assign io_link.tx_start = (state == BR_SEND_REPLY) && !io_link.tx_busy;
  assign io_link.tx_byte  = reply_q;

endmodule

`default_nettype wire

// File: uart_tx.sv
// 8n1 transmitter, one byte per start pulse; a start pulse while busy is ignored
`default_nettype none

`include "soc_defines.svh"

module uart_tx import uart_pkg::*; (
  input  logic    clk,
  input  logic    i_rst,
  uart_byte_if.tx i_link,
  output logic    o_tx
);

  localparam int CLKS = `SOC_CLKS_PER_BIT;
  localparam int CW   = $clog2(CLKS);

  uart_tx_state_t state;
  logic [CW-1:0]  clk_cnt;
  uart_bitcnt_t   bit_idx;
  uart_byte_t     shift_q;
  logic           busy_q;
  logic           bit_end;

  // every bit on the line lasts exactly CLKS cycles
  assign bit_end = (clk_cnt == CW'(CLKS - 1));

  // ====================
  // frame fsm
  // ====================

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state   <= TX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      busy_q  <= 1'b0;
      o_tx    <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (i_link.tx_start) begin
            // start bit and busy show up together, one cycle after the pulse
            o_tx   <= 1'b0;
            busy_q <= 1'b1;
            state  <= TX_START;
          end
        end
        TX_START: begin
          if (bit_end) begin
            clk_cnt <= '0;
            o_tx    <= shift_q[0];
            state   <= TX_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            clk_cnt <= '0;
            if (bit_idx == uart_bitcnt_t'(7)) begin
              // stop bit
              o_tx  <= 1'b1;
              state <= TX_STOP;
            end else begin
              o_tx    <= shift_q[0];
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        TX_STOP: begin
          if (bit_end) begin
            // 10 bit periods done, line stays high
            clk_cnt <= '0;
            busy_q  <= 1'b0;
            state   <= TX_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // byte latched on start, then shifted right as each data bit goes out
  always_ff @(posedge clk) begin
    if (state == TX_IDLE && i_link.tx_start) begin
      shift_q <= i_link.tx_byte;
    end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  assign i_link.tx_busy = busy_q;

endmodule

`default_nettype wire

// File: uart_rx.sv
// 8n1 receiver, fixed bit period, mid-bit sampling; rx_byte is only valid alongside the strobe
`default_nettype none

`include "soc_defines.svh"

module uart_rx import uart_pkg::*; (
  input  logic    clk,
  input  logic    i_rst,
  input  logic    i_rx,
  uart_byte_if.rx o_link
);

  localparam int CLKS = `SOC_CLKS_PER_BIT;
  localparam int HALF = CLKS / 2;
  localparam int CW   = $clog2(CLKS);

  logic           rx_meta;
  logic           rx_sync;
  uart_rx_state_t state;
  logic [CW-1:0]  clk_cnt;
  uart_bitcnt_t   bit_idx;
  uart_byte_t     shift_q;
  logic           strobe_q;
  logic           ferr_q;
  logic           bit_end;

  // ====================
  // input synchronizer
  // ====================

  // line idles high, so reset to 1 avoids a false start edge
  always_ff @(posedge clk) begin
    if (i_rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= i_rx;
      rx_sync <= rx_meta;
    end
  end

  // last cycle of a full bit period, counted from a mid-bit point
  assign bit_end = (clk_cnt == CW'(CLKS - 1));

  // ====================
  // frame fsm
  // ====================

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state    <= RX_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      strobe_q <= 1'b0;
      ferr_q   <= 1'b0;
    end else begin
      // pulses by default
      strobe_q <= 1'b0;
      ferr_q   <= 1'b0;
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          // falling edge seen on the synchronized line
          if (!rx_sync) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // half a bit in, the line must still be low
          if (clk_cnt == CW'(HALF - 1)) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            // high here means a glitch, drop it
            state   <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            clk_cnt <= '0;
            if (bit_idx == uart_bitcnt_t'(7)) begin
              state <= RX_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            clk_cnt  <= '0;
            // good stop bit gives the byte, a low one only flags the error
            strobe_q <= rx_sync;
            ferr_q   <= !rx_sync;
            // back to idle at once, the next start edge may follow directly
            state    <= RX_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // lsb arrives first, so data shifts in from the top
  always_ff @(posedge clk) begin
    if (state == RX_DATA && bit_end) begin
      shift_q <= {rx_sync, shift_q[7:1]};
    end
  end

  assign o_link.rx_byte      = shift_q;
  assign o_link.rx_strobe    = strobe_q;
  assign o_link.rx_frame_err = ferr_q;

endmodule

`default_nettype wire

// File: uart_byte_if.sv
// byte-level link between uart blocks and bridge; strobes are single-cycle, no flow control on rx
`default_nettype none

interface uart_byte_if import uart_pkg::*; ();

  // receive side, valid together with rx_strobe
  uart_byte_t rx_byte;
  // one cycle per good frame
  logic       rx_strobe;
  // one cycle instead of rx_strobe when the stop bit was low
  logic       rx_frame_err;

  // transmit side
  uart_byte_t tx_byte;
  // only pulsed while tx_busy is low
  logic       tx_start;
  // high for the whole frame, start through stop
  logic       tx_busy;

  // receiver produces bytes
  modport rx (
    output rx_byte,
    output rx_strobe,
    output rx_frame_err
  );

  // transmitter consumes one byte per start pulse
  modport tx (
    input  tx_byte,
    input  tx_start,
    output tx_busy
  );

  // bridge sits between both directions
  modport bridge (
    input  rx_byte,
    input  rx_strobe,
    input  rx_frame_err,
    input  tx_busy,
    output tx_byte,
    output tx_start
  );

endinterface

`default_nettype wire

// File: bridge_pkg.sv
// command and reply encodings of the serial gpio bridge; switch count must be 8 or less
`default_nettype none

`include "soc_defines.svh"

package bridge_pkg;

  // ====================
  // command bytes
  // ====================

  typedef logic [7:0] cmd_code_t;

  // 'W' followed by one data byte for the leds
  localparam cmd_code_t CMD_WRITE_LED = 8'h57;
  // 'R' asks for the switch value in the reply
  localparam cmd_code_t CMD_READ_SW   = 8'h52;

  // ====================
  // reply bytes
  // ====================

  typedef logic [7:0] reply_code_t;

  // 'K' after a completed led write
  localparam reply_code_t RPL_ACK     = 8'h4B;
  // '?' for any code the bridge does not know
  localparam reply_code_t RPL_UNKNOWN = 8'h3F;

  // ====================
  // board vectors
  // ====================

  typedef logic [`SOC_LED_WIDTH-1:0] led_t;
  typedef logic [`SOC_SW_WIDTH-1:0]  sw_t;

  // one command in flight at a time, no queue
  typedef enum logic [1:0] {
    BR_WAIT_CMD,
    BR_WAIT_DATA,
    BR_SEND_REPLY
  } bridge_state_t;

endpackage

`default_nettype wire

// File: uart_pkg.sv
// serial link types for an 8n1 frame only; no parity or second stop bit is modelled
`default_nettype none

package uart_pkg;

  // ====================
  // payload
  // ====================

  // one data byte as carried on the line, lsb first
  typedef logic [7:0] uart_byte_t;

  // index of a data bit inside the frame, 0..7 used
  // four bits leave room to count start and stop as well
  typedef logic [3:0] uart_bitcnt_t;

  // ====================
  // state machines
  // ====================

  // receiver steps through idle line, start check at mid-bit, eight data bits and stop check
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } uart_rx_state_t;

  // transmitter holds the line high when idle, then sends start low, data and stop high
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } uart_tx_state_t;

endpackage

`default_nettype wire

// File: soc_defines.svh
// build-time constants only; bit period must be at least 4 clocks, widths are fixed per board
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// ====================
// serial link timing
// ====================

// clocks per serial bit kept short so simulation stays fast
// a real board would use clk_hz / baud here
`define SOC_CLKS_PER_BIT 8

// ====================
// board gpio
// ====================

// number of user leds driven by the bridge
`define SOC_LED_WIDTH 8

// dip switch count of at most 8 so a read fits one reply byte
`define SOC_SW_WIDTH 4

`endif
